// File: verilog/aluPkg.sv
`default_nettype none

package aluPkg;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------

    // Codes 13 to 15 are not assigned
    typedef enum logic [3:0] {
        AddOp  = 4'd0,
        SubOp  = 4'd1,
        SubcOp = 4'd2,
        AndOp  = 4'd3,
        OrOp   = 4'd4,
        NotOp  = 4'd5,
        XorOp  = 4'd6,
        LsrAOp = 4'd7,
        LslAOp = 4'd8,
        LsrBOp = 4'd9,
        LslBOp = 4'd10,
        AsrAOp = 4'd11,
        AsrBOp = 4'd12
    } aluOpcodeT;

    // ----------------------------------------
    // Flags
    // ----------------------------------------

    localparam int FlagBits = 4;

    // Bit positions in the flag word
    localparam int ZeroFlag  = 0;
    localparam int CarryFlag = 1;
    localparam int NegFlag   = 2;
    localparam int OverFlag  = 3;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------

    localparam int ApbAddrBits = 8;
    localparam int ApbDataBits = 32;

    localparam logic [ApbAddrBits-1:0] RegOpA   = 8'h00;
    localparam logic [ApbAddrBits-1:0] RegOpB   = 8'h04;
    localparam logic [ApbAddrBits-1:0] RegCtrl  = 8'h08;
    localparam logic [ApbAddrBits-1:0] RegFlags = 8'h0C;
    localparam logic [ApbAddrBits-1:0] RegResult = 8'h10;

    // Slave error response levels
    localparam logic ApbRespOk  = 1'b0;
    localparam logic ApbRespErr = 1'b1;

    // True for the thirteen assigned opcodes
    function automatic logic opcodeValid(input logic [3:0] code);
        return code <= 4'(AsrBOp);
    endfunction

endpackage

`default_nettype wire

// File: verilog/aluOpIf.sv
`default_nettype none

// Operation handed from decode to execute
interface aluOpIf
    import aluPkg::*;
    #(
        parameter int Width = 8
    ) ();

    // One-cycle launch strobe
    logic             issue;
    aluOpcodeT        opcode;
    logic [Width-1:0] opA;
    logic [Width-1:0] opB;
    // Carry bit from current FLAGS
    logic             carryIn;

    // Register file side
    modport issuer (output issue, output opcode, output opA, output opB, output carryIn);

    // ALU side
    modport worker (input issue, input opcode, input opA, input opB, input carryIn);

endinterface

`default_nettype wire

// File: verilog/aluDecode.sv
`default_nettype none

module aluDecode
    import aluPkg::*;
    #(
        parameter int Width = 8
    ) (
        input  logic                   clock,
        input  logic                   reset,
        input  logic                   psel,
        input  logic                   penable,
        input  logic                   pwrite,
        input  logic [ApbAddrBits-1:0] paddr,
        input  logic [ApbDataBits-1:0] pwdata,
        output logic                   pready,
        output logic                   pslverr,
        aluOpIf.issuer                 op,
        input  logic                   done,
        input  logic [FlagBits-1:0]    flagsNow,
        output logic                   flagsWrite,
        output logic [FlagBits-1:0]    flagsData,
        output logic [ApbAddrBits-1:0] rdSel,
        output logic [Width-1:0]       rdOpA,
        output logic [Width-1:0]       rdOpB
    );

    logic             pending;
    logic             complete;
    logic             wrDone;
    logic             addrMapped;
    logic             ctrlValid;
    logic             badWrite;
    logic [Width-1:0] opAReg;
    logic [Width-1:0] opBReg;

    // ----------------------------------------
    // APB handshake
    // ----------------------------------------

    // Stall access phase while ALU busy
    assign pready   = !(pending && psel && penable);
    assign complete = psel && penable && pready;
    assign wrDone   = complete && pwrite;

    // Known word offsets only
    always_comb begin
        case (paddr)
            RegOpA, RegOpB, RegCtrl, RegFlags, RegResult: addrMapped = 1'b1;
            default: addrMapped = 1'b0;
        endcase
    end

    // Low nibble of CTRL carries opcode
    assign ctrlValid = opcodeValid(pwdata[3:0]);

    // RESULT is read-only; CTRL rejects unassigned codes
    assign badWrite = pwrite
                   && ((paddr == RegResult) || ((paddr == RegCtrl) && !ctrlValid));

    // Error only flagged in completing cycle
    assign pslverr = (complete && (!addrMapped || badWrite)) ? ApbRespErr : ApbRespOk;

    // ----------------------------------------
    // Operand registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            opAReg <= '0;
            opBReg <= '0;
        end else if (wrDone) begin
            if (paddr == RegOpA)
                opAReg <= pwdata[Width-1:0];
            if (paddr == RegOpB)
                opBReg <= pwdata[Width-1:0];
        end
    end

    assign rdOpA = opAReg;
    assign rdOpB = opBReg;
    assign rdSel = paddr;

    // Host write to FLAGS
    assign flagsWrite = wrDone && (paddr == RegFlags);
    assign flagsData  = pwdata[FlagBits-1:0];

    // ----------------------------------------
    // Issue and pending
    // ----------------------------------------

    assign op.issue   = wrDone && (paddr == RegCtrl) && ctrlValid;
    assign op.opcode  = aluOpcodeT'(pwdata[3:0]);
    assign op.opA     = opAReg;
    assign op.opB     = opBReg;
    assign op.carryIn = flagsNow[CarryFlag];

    // Single operation in flight, cleared once done is seen
    always_ff @(posedge clock) begin
        if (reset)
            pending <= 1'b0;
        else if (op.issue)
            pending <= 1'b1;
        else if (done)
            pending <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
`default_nettype none

module aluExecute
    import aluPkg::*;
    #(
        parameter int Width = 8
    ) (
        input  logic                clock,
        input  logic                reset,
        aluOpIf.worker              op,
        output logic                done,
        output logic [Width-1:0]    value,
        output logic [FlagBits-1:0] flags
    );

    // Captured operation
    logic             busy;
    aluOpcodeT        opcodeQ;
    logic [Width-1:0] aQ;
    logic [Width-1:0] bQ;
    logic             cinQ;

    // Combinational datapath
    logic [Width-1:0] addend;
    logic             addCin;
    logic [Width:0]   sum;
    logic [Width-1:0] shiftSrc;
    logic [Width-1:0] res;
    logic             carry;
    logic             over;

    // ----------------------------------------
    // Operand capture
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset)
            busy <= 1'b0;
        else
            busy <= op.issue;
    end

    always_ff @(posedge clock) begin
        if (op.issue) begin
            opcodeQ <= op.opcode;
            aQ      <= op.opA;
            bQ      <= op.opB;
            cinQ    <= op.carryIn;
        end
    end

    // ----------------------------------------
    // Adder
    // ----------------------------------------

    // Sub and Subc add the complement of B
    always_comb begin
        addend  = ~bQ;
        addCin  = 1'b1;
        case (opcodeQ)
            AddOp: begin
                addend = bQ;
                addCin = cinQ;
            end
            SubOp: addCin = 1'b1;
            // Extra one only without borrow
            SubcOp: addCin = !cinQ;
            default: ;
        endcase
    end

    assign sum = {1'b0, aQ} + {1'b0, addend} + {{Width{1'b0}}, addCin};

    // B-side shifts share the A-side logic
    assign shiftSrc = (opcodeQ == LsrBOp || opcodeQ == LslBOp || opcodeQ == AsrBOp) ? bQ : aQ;

    // ----------------------------------------
    // Result and carry
    // ----------------------------------------

    always_comb begin
        res   = '0;
        carry = 1'b0;
        over  = 1'b0;
        case (opcodeQ)
            AddOp, SubOp, SubcOp: begin
                res   = sum[Width-1:0];
                carry = sum[Width];
                // Equal addend signs, result sign flipped
                over  = (aQ[Width-1] == addend[Width-1])
                     && (sum[Width-1] != aQ[Width-1]);
            end
            // Logic ops leave carry clear
            AndOp: res = aQ & bQ;
            OrOp:  res = aQ | bQ;
            NotOp: res = ~aQ;
            XorOp: res = aQ ^ bQ;
            LsrAOp, LsrBOp: begin
                res   = {1'b0, shiftSrc[Width-1:1]};
                carry = shiftSrc[0];
            end
            LslAOp, LslBOp: begin
                res   = {shiftSrc[Width-2:0], 1'b0};
                carry = shiftSrc[Width-1];
                // 6809 rule for left shift
                over  = shiftSrc[Width-1] ^ shiftSrc[Width-2];
            end
            AsrAOp, AsrBOp: begin
                // Sign bit replicated
                res   = {shiftSrc[Width-1], shiftSrc[Width-1:1]};
                carry = shiftSrc[0];
            end
            default: begin
                res   = '0;
                carry = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset)
            done <= 1'b0;
        else
            done <= busy;
    end

    always_ff @(posedge clock) begin
        if (busy) begin
            value           <= res;
            flags[ZeroFlag]  <= (res == '0);
            flags[CarryFlag] <= carry;
            flags[NegFlag]   <= res[Width-1];
            flags[OverFlag]  <= over;
        end
    end

endmodule

`default_nettype wire

// File: verilog/aluResult.sv
`default_nettype none

module aluResult
    import aluPkg::*;
    #(
        parameter int Width = 8
    ) (
        input  logic                   clock,
        input  logic                   reset,
        input  logic                   done,
        input  logic [Width-1:0]       value,
        input  logic [FlagBits-1:0]    flags,
        input  logic                   flagsWrite,
        input  logic [FlagBits-1:0]    flagsData,
        input  logic [ApbAddrBits-1:0] rdSel,
        input  logic [Width-1:0]       rdOpA,
        input  logic [Width-1:0]       rdOpB,
        output logic [FlagBits-1:0]    flagsNow,
        output logic [ApbDataBits-1:0] prdata
    );

    logic [Width-1:0]    resultReg;
    logic [FlagBits-1:0] flagsReg;

    // ----------------------------------------
    // RESULT and FLAGS
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset)
            resultReg <= '0;
        else if (done)
            resultReg <= value;
    end

    // ALU update or host write, never both at once
    always_ff @(posedge clock) begin
        if (reset)
            flagsReg <= '0;
        else if (done)
            flagsReg <= flags;
        else if (flagsWrite)
            flagsReg <= flagsData;
    end

    // Carry feeds the next operation
    assign flagsNow = flagsReg;

    // ----------------------------------------
    // Read mux
    // ----------------------------------------

    // Zero above the register width
    always_comb begin
        prdata = '0;
        case (rdSel)
            RegOpA:    prdata[Width-1:0]    = rdOpA;
            RegOpB:    prdata[Width-1:0]    = rdOpB;
            RegFlags:  prdata[FlagBits-1:0] = flagsReg;
            RegResult: prdata[Width-1:0]    = resultReg;
            // CTRL is write-only
            default:   prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/apbAlu.sv
`default_nettype none

module apbAlu
    import aluPkg::*;
    #(
        parameter int Width = 8
    ) (
        input  logic                   clock,
        input  logic                   reset,
        // APB3 slave
        input  logic                   psel,
        input  logic                   penable,
        input  logic                   pwrite,
        input  logic [ApbAddrBits-1:0] paddr,
        input  logic [ApbDataBits-1:0] pwdata,
        output logic [ApbDataBits-1:0] prdata,
        output logic                   pready,
        output logic                   pslverr
    );

    // Execute to result
    logic                   done;
    logic [Width-1:0]       value;
    logic [FlagBits-1:0]    flags;

    // Decode and result cross links
    logic                   flagsWrite;
    logic [FlagBits-1:0]    flagsData;
    logic [ApbAddrBits-1:0] rdSel;
    logic [Width-1:0]       rdOpA;
    logic [Width-1:0]       rdOpB;
    logic [FlagBits-1:0]    flagsNow;

    aluOpIf #(.Width(Width)) opBus ();

    // ----------------------------------------
    // Stages
    // ----------------------------------------

    aluDecode #(.Width(Width)) i_decode (
        .clock      (clock),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .op         (opBus.issuer),
        .done       (done),
        .flagsNow   (flagsNow),
        .flagsWrite (flagsWrite),
        .flagsData  (flagsData),
        .rdSel      (rdSel),
        .rdOpA      (rdOpA),
        .rdOpB      (rdOpB)
    );

    aluExecute #(.Width(Width)) i_execute (
        .clock (clock),
        .reset (reset),
        .op    (opBus.worker),
        .done  (done),
        .value (value),
        .flags (flags)
    );

    aluResult #(.Width(Width)) i_result (
        .clock      (clock),
        .reset      (reset),
        .done       (done),
        .value      (value),
        .flags      (flags),
        .flagsWrite (flagsWrite),
        .flagsData  (flagsData),
        .rdSel      (rdSel),
        .rdOpA      (rdOpA),
        .rdOpB      (rdOpB),
        .flagsNow   (flagsNow),
        .prdata     (prdata)
    );

endmodule

`default_nettype wire

// File: sim/apbAluTb.sv
`default_nettype none

module apbAluTb
    import aluPkg::*;
    ();

    localparam int Width      = 8;
    localparam int HalfPeriod = 5;
    // Combinational outputs settled this long after the falling edge
    localparam int SettleTime = 1;

    // ----------------------------------------
    // Run length and timeout
    // ----------------------------------------

    localparam int ArithPairs  = 100;
    localparam int ArithCorner = 5;
    localparam int UnitOps     = 10;
    localparam int UnitRounds  = 6;
    // Six accesses per operation, rest covers readback, stall and error tests
    localparam int AccessCount = (ArithPairs + ArithCorner) * 6
                               + (UnitOps * UnitRounds + 2) * 6 + 80;
    // Up to five cycles per access, plus reset
    localparam int TimeoutCycles = AccessCount * 5 + 100;

    localparam aluOpcodeT ArithList [3] = '{AddOp, SubOp, SubcOp};
    localparam aluOpcodeT UnitList [UnitOps] = '{AndOp, OrOp, NotOp, XorOp, LsrAOp,
                                                 LslAOp, LsrBOp, LslBOp, AsrAOp, AsrBOp};

    // FLAGS word with only carry set
    localparam logic [FlagBits-1:0] CarrySet = 4'b0010;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [ApbAddrBits-1:0] paddr;
    logic [ApbDataBits-1:0] pwdata;
    logic [ApbDataBits-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    // Bookkeeping
    int          cycleCount  = 0;
    int          checkCount  = 0;
    int          errorCount  = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          testStart;
    string       testName;
    logic [31:0] rngState = 32'h84c3_02a1;

    apbAlu #(.Width(Width)) i_dut (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        forever #HalfPeriod clock = ~clock;
    end

    // Hung handshake guard
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: no finish after %0d cycles, stuck in %s",
                     TimeoutCycles, testName);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s in %s: got 0x%h, expected 0x%h",
                     name, testName, actual, expected);
        end
    endtask

    task automatic beginTest(input string name);
        testName  = name;
        testStart = errorCount;
    endtask

    task automatic endTest();
        int mismatches;
        mismatches = errorCount - testStart;
        if (mismatches == 0)
            testsPassed++;
        else
            testsFailed++;
        $display("%s finished, %0d mismatches", testName, mismatches);
    endtask

    // Expected {flags, result}, built from the opcode rules
    function automatic logic [FlagBits+Width-1:0] aluModel(input aluOpcodeT opc,
        input logic [Width-1:0] a, input logic [Width-1:0] b, input logic cin);
        logic [Width:0]      full;
        logic [Width-1:0]    src;
        logic [Width-1:0]    res;
        logic                c;
        logic                v;
        logic [FlagBits-1:0] f;
        res = '0;
        c   = 1'b0;
        v   = 1'b0;
        src = (opc == LsrBOp || opc == LslBOp || opc == AsrBOp) ? b : a;
        case (opc)
            AddOp: begin
                full = {1'b0, a} + {1'b0, b} + {{Width{1'b0}}, cin};
                res  = full[Width-1:0];
                c    = full[Width];
                v    = (a[Width-1] == b[Width-1]) && (res[Width-1] != a[Width-1]);
            end
            SubOp, SubcOp: begin
                // Carry out set means no borrow
                full = {1'b0, a} + {1'b0, ~b}
                     + {{Width{1'b0}}, (opc == SubOp) ? 1'b1 : !cin};
                res  = full[Width-1:0];
                c    = full[Width];
                v    = (a[Width-1] != b[Width-1]) && (res[Width-1] != a[Width-1]);
            end
            AndOp: res = a & b;
            OrOp:  res = a | b;
            NotOp: res = ~a;
            XorOp: res = a ^ b;
            LsrAOp, LsrBOp: begin
                res = src >> 1;
                c   = src[0];
            end
            LslAOp, LslBOp: begin
                res = src << 1;
                c   = src[Width-1];
                v   = src[Width-1] ^ src[Width-2];
            end
            AsrAOp, AsrBOp: begin
                res = $signed(src) >>> 1;
                c   = src[0];
            end
            default: res = '0;
        endcase
        f[ZeroFlag]  = (res == '0);
        f[CarryFlag] = c;
        f[NegFlag]   = res[Width-1];
        f[OverFlag]  = v;
        return {f, res};
    endfunction

    // ----------------------------------------
    // APB master
    // ----------------------------------------

    // Returns right after the completing edge, bus still driven
    task automatic apbWrite(input logic [ApbAddrBits-1:0] addr,
                            input logic [ApbDataBits-1:0] data, output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clock);
        penable = 1'b1;
        #SettleTime;
        while (!pready) begin
            @(negedge clock);
            #SettleTime;
        end
        err = pslverr;
        @(posedge clock);
    endtask

    task automatic apbRead(input logic [ApbAddrBits-1:0] addr,
                           output logic [ApbDataBits-1:0] data, output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clock);
        penable = 1'b1;
        #SettleTime;
        while (!pready) begin
            @(negedge clock);
            #SettleTime;
        end
        data = prdata;
        err  = pslverr;
        @(posedge clock);
    endtask

    task automatic releaseBus();
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic writeAndCompare(input logic [ApbAddrBits-1:0] addr,
        input logic [ApbDataBits-1:0] data, input string name, input logic expErr);
        logic err;
        apbWrite(addr, data, err);
        checkValue(name, 32'(err), 32'(expErr));
    endtask

    task automatic readAndCompare(input logic [ApbAddrBits-1:0] addr, input string name,
        input logic [ApbDataBits-1:0] expData, input logic expErr);
        logic                   err;
        logic [ApbDataBits-1:0] data;
        apbRead(addr, data, err);
        checkValue(name, data, expData);
        checkValue({name, " pslverr"}, 32'(err), 32'(expErr));
    endtask

    // Full host sequence for one operation
    task automatic runOperation(input aluOpcodeT opc, input logic [Width-1:0] a,
        input logic [Width-1:0] b, input logic [FlagBits-1:0] flagsIn);
        logic [FlagBits+Width-1:0] expected;
        string                     tag;
        expected = aluModel(opc, a, b, flagsIn[CarryFlag]);
        tag      = $sformatf("op %0d a %h b %h flags %h", opc, a, b, flagsIn);
        writeAndCompare(RegOpA, 32'(a), "pslverr OPA write", 1'b0);
        writeAndCompare(RegOpB, 32'(b), "pslverr OPB write", 1'b0);
        writeAndCompare(RegFlags, 32'(flagsIn), "pslverr FLAGS write", 1'b0);
        writeAndCompare(RegCtrl, 32'(opc), "pslverr CTRL write", 1'b0);
        readAndCompare(RegResult, {"RESULT ", tag}, 32'(expected[Width-1:0]), 1'b0);
        readAndCompare(RegFlags, {"FLAGS ", tag},
                       32'(expected[FlagBits+Width-1:Width]), 1'b0);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic resetReadback();
        beginTest("resetReadback");
        readAndCompare(RegOpA, "OPA after reset", 32'h0, 1'b0);
        readAndCompare(RegOpB, "OPB after reset", 32'h0, 1'b0);
        readAndCompare(RegFlags, "FLAGS after reset", 32'h0, 1'b0);
        readAndCompare(RegResult, "RESULT after reset", 32'h0, 1'b0);
        // Upper bits dropped on write
        writeAndCompare(RegOpA, 32'hDEAD_BEA5, "pslverr OPA write", 1'b0);
        writeAndCompare(RegOpB, 32'h1234_5678, "pslverr OPB write", 1'b0);
        readAndCompare(RegOpA, "OPA readback", 32'h0000_00A5, 1'b0);
        readAndCompare(RegOpB, "OPB readback", 32'h0000_0078, 1'b0);
        endTest();
    endtask

    task automatic arithmeticOps();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rf;
        beginTest("arithmeticOps");
        // Overflow and borrow corners
        runOperation(AddOp, 8'h7F, 8'h01, 4'h0);
        runOperation(SubOp, 8'h80, 8'h01, 4'h0);
        runOperation(SubOp, 8'h00, 8'h01, 4'h0);
        runOperation(SubcOp, 8'h00, 8'h00, CarrySet);
        runOperation(AddOp, 8'hFF, 8'h00, CarrySet);
        for (int i = 0; i < ArithPairs; i++) begin
            nextRandom(ra);
            nextRandom(rb);
            nextRandom(rf);
            runOperation(ArithList[i % 3], ra[Width-1:0], rb[Width-1:0], rf[FlagBits-1:0]);
        end
        endTest();
    endtask

    task automatic logicAndShifts();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rf;
        beginTest("logicAndShifts");
        // Zero results, carry set beforehand
        runOperation(AndOp, 8'hF0, 8'h0F, 4'hF);
        runOperation(LsrAOp, 8'h01, 8'h00, 4'h0);
        for (int r = 0; r < UnitRounds; r++) begin
            for (int k = 0; k < UnitOps; k++) begin
                nextRandom(ra);
                nextRandom(rb);
                nextRandom(rf);
                runOperation(UnitList[k], ra[Width-1:0], rb[Width-1:0], rf[FlagBits-1:0]);
            end
        end
        endTest();
    endtask

    task automatic backPressure();
        logic [FlagBits+Width-1:0] expected;
        logic [Width-1:0]          a;
        beginTest("backPressure");
        for (int i = 0; i < 4; i++) begin
            // Distinct A each round, so a stale RESULT shows
            a        = Width'(19 * (i + 1));
            expected = aluModel(XorOp, a, 8'h5A, 1'b0);
            writeAndCompare(RegOpA, 32'(a), "pslverr OPA write", 1'b0);
            writeAndCompare(RegOpB, 32'h5A, "pslverr OPB write", 1'b0);
            writeAndCompare(RegCtrl, 32'(XorOp), "pslverr CTRL write", 1'b0);
            // Setup phase starts right behind the CTRL write
            readAndCompare(RegResult, "RESULT behind CTRL", 32'(expected[Width-1:0]), 1'b0);
        end
        endTest();
    endtask

    task automatic errorResponses();
        logic [FlagBits+Width-1:0] expected;
        beginTest("errorResponses");
        runOperation(AddOp, 8'h7F, 8'h01, 4'h0);
        expected = aluModel(AddOp, 8'h7F, 8'h01, 1'b0);
        for (int code = 13; code <= 15; code++)
            writeAndCompare(RegCtrl, 32'(code), "pslverr bad opcode", 1'b1);
        writeAndCompare(RegResult, 32'h55, "pslverr RESULT write", 1'b1);
        writeAndCompare(8'h14, 32'hAA, "pslverr unmapped write", 1'b1);
        writeAndCompare(8'h0E, 32'h01, "pslverr unaligned write", 1'b1);
        readAndCompare(8'h40, "unmapped read", 32'h0, 1'b1);
        // Nothing above may touch RESULT or FLAGS
        readAndCompare(RegResult, "RESULT kept", 32'(expected[Width-1:0]), 1'b0);
        readAndCompare(RegFlags, "FLAGS kept", 32'(expected[FlagBits+Width-1:Width]), 1'b0);
        endTest();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        testName = "reset";
        repeat (5) @(negedge clock);
        reset = 1'b0;
        resetReadback();
        arithmeticOps();
        logicAndShifts();
        backPressure();
        errorResponses();
        releaseBus();
        $display("Tests passed %0d, failed %0d; checks %0d, mismatches %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/aluPkg.sv
verilog/aluOpIf.sv
verilog/aluDecode.sv
verilog/aluExecute.sv
verilog/aluResult.sv
verilog/apbAlu.sv
sim/apbAluTb.sv

// File: Makefile
TOP := apbAluTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f verilog/*.sv sim/*.sv
	verilator --binary --timing -j 0 -f sources.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx '\*\*\* PASSED \*\*\*'

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module apbAlu

clean:
	rm -rf obj_dir
